//--- Bender.yml
package:
  name: rv_exec

sources:
  - hdl/rv_exec_pkg.sv
  - hdl/rv_dec_if.sv
  - hdl/rv_idu.sv
  - hdl/rv_regfile.sv
  - hdl/rv_alu.sv
  - hdl/rv_exec_ctrl.sv
  - hdl/rv_exec_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_exec_top.sv

//--- hdl/rv_alu.sv
`timescale 1ns/100ps

module rv_alu import rv_exec_pkg::*; (
   rv_dec_if.user dec,
   input  xlen_t  i_pc,
   input  xlen_t  i_rs1_data,
   input  xlen_t  i_rs2_data,
   output xlen_t  o_value,
   output logic   o_taken,
   output xlen_t  o_target
);

   xlen_t       op_a;
   xlen_t       op_b;
   xlen_t       res64;
   logic [31:0] res32;
   xlen_t       result;
   logic        cmp;

   always_comb begin
      case (dec.op_a_sel)
         PC:      op_a = i_pc;
         ZERO:    op_a = '0;
         default: op_a = i_rs1_data;
      endcase
   end

   assign op_b = (dec.op_b_sel == IMM) ? dec.imm : i_rs2_data;

   // ---------------------------------------
   // Full width and W form datapaths
   // ---------------------------------------
   always_comb begin
      case (dec.alu_op)
         SUB:     res64 = op_a - op_b;
         SLL:     res64 = op_a << op_b[5:0];
         SLT:     res64 = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
         SLTU:    res64 = {{(XLEN-1){1'b0}}, (op_a < op_b)};
         XOR:     res64 = op_a ^ op_b;
         SRL:     res64 = op_a >> op_b[5:0];
         SRA:     res64 = $signed(op_a) >>> op_b[5:0];
         OR:      res64 = op_a | op_b;
         AND:     res64 = op_a & op_b;
         PASS_B:  res64 = op_b;
         default: res64 = op_a + op_b;
      endcase
   end

   always_comb begin
      case (dec.alu_op)
         SUB:     res32 = op_a[31:0] - op_b[31:0];
         SLL:     res32 = op_a[31:0] << op_b[4:0];
         SRL:     res32 = op_a[31:0] >> op_b[4:0];
         SRA:     res32 = $signed(op_a[31:0]) >>> op_b[4:0];
         default: res32 = op_a[31:0] + op_b[31:0];
      endcase
   end

   assign result = dec.word ? {{(XLEN-32){res32[31]}}, res32} : res64;

   // Branch condition.
   always_comb begin
      case (dec.cmp_op)
         NE:      cmp = (i_rs1_data != i_rs2_data);
         LT:      cmp = ($signed(i_rs1_data) < $signed(i_rs2_data));
         GE:      cmp = ($signed(i_rs1_data) >= $signed(i_rs2_data));
         LTU:     cmp = (i_rs1_data < i_rs2_data);
         GEU:     cmp = (i_rs1_data >= i_rs2_data);
         default: cmp = (i_rs1_data == i_rs2_data);
      endcase
   end

   assign o_value  = (dec.kind == JUMP) ? i_pc + XLEN'(4) : result;  // Link address.
   assign o_taken  = (dec.kind == JUMP) || (dec.kind == BRANCH && cmp);
   assign o_target = (dec.kind == JUMP && dec.op_a_sel == RS1) ?
                     {result[XLEN-1:1], 1'b0} : result;

endmodule

//--- hdl/rv_dec_if.sv
`timescale 1ns/100ps

interface rv_dec_if import rv_exec_pkg::*; ();

   reg_addr_t         rs1;
   reg_addr_t         rs2;
   reg_addr_t         rd;
   xlen_t             imm;       // Sign-extended.
   alu_op_e           alu_op;
   cmp_op_e           cmp_op;
   op_a_sel_e         op_a_sel;
   op_b_sel_e         op_b_sel;
   logic              word;      // 32-bit W form.
   logic              rd_we;
   res_kind_e         kind;
   logic [SIZE_W-1:0] size;
   logic              sigext;    // Signed load.

   modport dec (
      output rs1, rs2, rd, imm, alu_op, cmp_op, op_a_sel, op_b_sel,
      output word, rd_we, kind, size, sigext
   );

   modport user (
      input rs1, rs2, rd, imm, alu_op, cmp_op, op_a_sel, op_b_sel,
      input word, rd_we, kind, size, sigext
   );

endinterface

//--- hdl/rv_exec_ctrl.sv
`timescale 1ns/100ps

module rv_exec_ctrl import rv_exec_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  logic              i_insn_valid,
   input  insn_t             i_insn,
   input  xlen_t             i_pc,
   output logic              o_insn_credit,
   output insn_t             o_head_insn,
   output xlen_t             o_head_pc,
   rv_dec_if.user            dec,
   input  xlen_t             i_value,
   input  logic              i_taken,
   input  xlen_t             i_target,
   output logic              o_rf_we,
   input  logic              i_res_credit,
   output logic              o_res_valid,
   output res_kind_e         o_res_kind,
   output reg_addr_t         o_res_rd,
   output xlen_t             o_res_value,
   output logic              o_res_taken,
   output xlen_t             o_res_target,
   output logic [SIZE_W-1:0] o_res_size
);

   insn_t                q_insn [INSN_CREDITS];
   xlen_t                q_pc   [INSN_CREDITS];
   logic [QPTR_W-1:0]    wr_ptr;
   logic [QPTR_W-1:0]    rd_ptr;
   logic [QCNT_W-1:0]    q_cnt;
   logic [RES_CNT_W-1:0] res_cnt;
   logic                 issue;

   assign issue       = (q_cnt != '0) && (res_cnt != '0);
   assign o_head_insn = q_insn[rd_ptr];
   assign o_head_pc   = q_pc[rd_ptr];
   assign o_rf_we     = issue && dec.rd_we;  // Write lands on the issuing edge.

   // ---------------------------------------
   // Instruction queue
   // ---------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_insn_valid) begin
         q_insn[wr_ptr] <= i_insn;
         q_pc[wr_ptr]   <= i_pc;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         q_cnt   <= '0;
         res_cnt <= RES_CNT_W'(RES_CREDITS);
      end else begin
         if (i_insn_valid)
            wr_ptr <= wr_ptr + QPTR_W'(1);
         if (issue)
            rd_ptr <= rd_ptr + QPTR_W'(1);
         q_cnt   <= q_cnt + QCNT_W'(i_insn_valid) - QCNT_W'(issue);
         res_cnt <= res_cnt + RES_CNT_W'(i_res_credit) - RES_CNT_W'(issue);
      end
   end

   // ---------------------------------------
   // Credit return and retire register
   // ---------------------------------------
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_insn_credit <= 1'b0;
         o_res_valid   <= 1'b0;
      end else begin
         o_insn_credit <= issue;
         o_res_valid   <= issue;
      end
   end

   always_ff @(posedge i_clk) begin
      if (issue) begin
         o_res_kind   <= dec.kind;
         o_res_rd     <= dec.rd;
         o_res_value  <= i_value;
         o_res_taken  <= i_taken;
         o_res_target <= i_target;
         o_res_size   <= dec.size;
      end
   end

endmodule

//--- hdl/rv_exec_pkg.sv
package rv_exec_pkg;

   // ---------------------------------------
   // Widths and basic types
   // ---------------------------------------
   localparam int XLEN = 64;

   typedef logic [XLEN-1:0] xlen_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [31:0]     insn_t;

   localparam int SIZE_W = 2;  // Log2 of access size.

   // ---------------------------------------
   // Credits and queue sizing
   // ---------------------------------------
   localparam int INSN_CREDITS = 2;
   localparam int RES_CREDITS  = 4;

   localparam int QPTR_W    = $clog2(INSN_CREDITS);
   localparam int QCNT_W    = $clog2(INSN_CREDITS + 1);
   localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

   // ---------------------------------------
   // Major opcodes
   // ---------------------------------------
   localparam logic [6:0] OPC_LOAD      = 7'b0000011;
   localparam logic [6:0] OPC_STORE     = 7'b0100011;
   localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
   localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
   localparam logic [6:0] OPC_OP        = 7'b0110011;
   localparam logic [6:0] OPC_OP_32     = 7'b0111011;
   localparam logic [6:0] OPC_LUI       = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
   localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
   localparam logic [6:0] OPC_JAL       = 7'b1101111;
   localparam logic [6:0] OPC_JALR      = 7'b1100111;

   // ---------------------------------------
   // Decoded control fields
   // ---------------------------------------
   typedef enum logic [3:0] {
      ADD,
      SUB,
      SLL,
      SLT,
      SLTU,
      XOR,
      SRL,
      SRA,
      OR,
      AND,
      PASS_B
   } alu_op_e;

   typedef enum logic [2:0] {
      EQ,
      NE,
      LT,
      GE,
      LTU,
      GEU
   } cmp_op_e;

   typedef enum logic [1:0] {RS1, PC, ZERO} op_a_sel_e;

   typedef enum logic {RS2, IMM} op_b_sel_e;

   typedef enum logic [2:0] {
      ALU,
      JUMP,
      BRANCH,
      LOAD,
      STORE,
      ILLEGAL
   } res_kind_e;

endpackage

//--- hdl/rv_exec_top.sv
`timescale 1ns/100ps

module rv_exec_top import rv_exec_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  logic              i_insn_valid,
   input  insn_t             i_insn,
   input  xlen_t             i_pc,
   output logic              o_insn_credit,
   input  logic              i_res_credit,
   output logic              o_res_valid,
   output res_kind_e         o_res_kind,
   output reg_addr_t         o_res_rd,
   output xlen_t             o_res_value,
   output logic              o_res_taken,
   output xlen_t             o_res_target,
   output logic [SIZE_W-1:0] o_res_size
);

   insn_t head_insn;
   xlen_t head_pc;
   xlen_t rs1_data;
   xlen_t rs2_data;
   xlen_t value;
   logic  taken;
   xlen_t target;
   logic  rf_we;

   rv_dec_if dec_if ();

   rv_exec_ctrl i_ctrl (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_insn_valid  (i_insn_valid),
      .i_insn        (i_insn),
      .i_pc          (i_pc),
      .o_insn_credit (o_insn_credit),
      .o_head_insn   (head_insn),
      .o_head_pc     (head_pc),
      .dec           (dec_if.user),
      .i_value       (value),
      .i_taken       (taken),
      .i_target      (target),
      .o_rf_we       (rf_we),
      .i_res_credit  (i_res_credit),
      .o_res_valid   (o_res_valid),
      .o_res_kind    (o_res_kind),
      .o_res_rd      (o_res_rd),
      .o_res_value   (o_res_value),
      .o_res_taken   (o_res_taken),
      .o_res_target  (o_res_target),
      .o_res_size    (o_res_size)
   );

   rv_idu i_idu (
      .i_insn (head_insn),
      .dec    (dec_if.dec)
   );

   rv_regfile i_regfile (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rs1      (dec_if.rs1),
      .i_rs2      (dec_if.rs2),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (rf_we),
      .i_rd       (dec_if.rd),
      .i_wdata    (value)        // ALU result or link address.
   );

   rv_alu i_alu (
      .dec        (dec_if.user),
      .i_pc       (head_pc),
      .i_rs1_data (rs1_data),
      .i_rs2_data (rs2_data),
      .o_value    (value),
      .o_taken    (taken),
      .o_target   (target)
   );

endmodule

//--- hdl/rv_idu.sv
`timescale 1ns/100ps

module rv_idu import rv_exec_pkg::*; (
   input  insn_t    i_insn,
   rv_dec_if.dec    dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rd;
   xlen_t      imm_i;
   xlen_t      imm_s;
   xlen_t      imm_b;
   xlen_t      imm_u;
   xlen_t      imm_j;
   res_kind_e  kind;

   function automatic alu_op_e alu_f3(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? SUB : ADD;
         3'b001:  return SLL;
         3'b010:  return SLT;
         3'b011:  return SLTU;
         3'b100:  return XOR;
         3'b101:  return alt ? SRA : SRL;
         3'b110:  return OR;
         default: return AND;
      endcase
   endfunction

   assign opcode = i_insn[6:0];
   assign funct3 = i_insn[14:12];
   assign funct7 = i_insn[31:25];
   assign rd     = i_insn[11:7];

   assign dec.rs1 = i_insn[19:15];
   assign dec.rs2 = i_insn[24:20];
   assign dec.rd  = rd;

   // ---------------------------------------
   // Immediate formats
   // ---------------------------------------
   assign imm_i = {{(XLEN-12){i_insn[31]}}, i_insn[31:20]};
   assign imm_s = {{(XLEN-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
   assign imm_b = {{(XLEN-13){i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                   i_insn[11:8], 1'b0};
   assign imm_u = {{(XLEN-32){i_insn[31]}}, i_insn[31:12], 12'd0};
   assign imm_j = {{(XLEN-21){i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                   i_insn[30:21], 1'b0};

   // ---------------------------------------
   // Opcode decode
   // ---------------------------------------
   always_comb begin
      kind         = ILLEGAL;
      dec.imm      = imm_i;
      dec.alu_op   = ADD;
      dec.cmp_op   = EQ;
      dec.op_a_sel = RS1;
      dec.op_b_sel = IMM;
      dec.word     = 1'b0;
      dec.size     = funct3[1:0];
      dec.sigext   = 1'b0;
      case (opcode)
         OPC_OP_IMM: begin
            dec.alu_op = alu_f3(funct3, funct3 == 3'b101 && i_insn[30]);
            if (funct3 == 3'b001)
               kind = (i_insn[31:26] == 6'd0) ? ALU : ILLEGAL;
            else if (funct3 == 3'b101)
               kind = (i_insn[31:26] == 6'd0 || i_insn[31:26] == 6'b010000) ? ALU : ILLEGAL;
            else
               kind = ALU;
         end
         OPC_OP_IMM_32: begin
            dec.word   = 1'b1;
            dec.alu_op = alu_f3(funct3, funct3 == 3'b101 && i_insn[30]);
            if (funct3 == 3'b000)
               kind = ALU;
            else if (funct3 == 3'b001 || funct3 == 3'b101)
               kind = (funct7 == 7'd0 || (funct3 == 3'b101 && funct7 == 7'b0100000)) ?
                      ALU : ILLEGAL;
         end
         OPC_OP, OPC_OP_32: begin
            dec.word     = (opcode == OPC_OP_32);
            dec.op_b_sel = RS2;
            dec.alu_op   = alu_f3(funct3, funct7[5]);
            if ((opcode == OPC_OP || funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101) &&
                (funct7 == 7'd0 ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))))
               kind = ALU;
         end
         OPC_LUI: begin
            kind         = ALU;
            dec.imm      = imm_u;
            dec.op_a_sel = ZERO;
            dec.alu_op   = PASS_B;
         end
         OPC_AUIPC: begin
            kind         = ALU;
            dec.imm      = imm_u;
            dec.op_a_sel = PC;
         end
         OPC_JAL: begin
            kind         = JUMP;
            dec.imm      = imm_j;
            dec.op_a_sel = PC;
         end
         OPC_JALR: begin
            if (funct3 == 3'b000)
               kind = JUMP;
         end
         OPC_BRANCH: begin
            dec.imm      = imm_b;
            dec.op_a_sel = PC;
            case (funct3)
               3'b000:  dec.cmp_op = EQ;
               3'b001:  dec.cmp_op = NE;
               3'b100:  dec.cmp_op = LT;
               3'b101:  dec.cmp_op = GE;
               3'b110:  dec.cmp_op = LTU;
               default: dec.cmp_op = GEU;
            endcase
            if (funct3[2:1] != 2'b01)
               kind = BRANCH;
         end
         OPC_LOAD: begin
            dec.sigext = ~funct3[2];  // LBU, LHU, LWU zero-extend.
            if (funct3 != 3'b111)
               kind = LOAD;
         end
         OPC_STORE: begin
            dec.imm = imm_s;
            if (!funct3[2])
               kind = STORE;
         end
         default: kind = ILLEGAL;
      endcase
   end

   assign dec.kind  = kind;
   assign dec.rd_we = (kind == ALU || kind == JUMP) && (rd != 5'd0);

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile import rv_exec_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst_n,
   input  reg_addr_t i_rs1,
   input  reg_addr_t i_rs2,
   output xlen_t     o_rs1_data,
   output xlen_t     o_rs2_data,
   input  logic      i_we,
   input  reg_addr_t i_rd,
   input  xlen_t     i_wdata
);

   xlen_t regs [32];

   // ---------------------------------------
   // Write port
   // ---------------------------------------
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_rd != 5'd0) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // ---------------------------------------
   // Read ports
   // ---------------------------------------
   assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];  // x0 is hardwired.
   assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

//--- rv_exec_top.f
+incdir+sim
hdl/rv_exec_pkg.sv
hdl/rv_dec_if.sv
hdl/rv_idu.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_exec_ctrl.sv
hdl/rv_exec_top.sv
sim/tb_rv_exec_top.sv

//--- sim/tb_rv_exec_ref.svh
// ---------------------------------------
// Reference model
// ---------------------------------------
typedef struct {
   res_kind_e         kind;
   reg_addr_t         rd;
   xlen_t             value;
   logic              taken;
   xlen_t             target;
   logic [SIZE_W-1:0] size;
   logic              rd_we;
   int                lat;       // Required latency, 0 for none.
   int                sent;
} exp_t;

xlen_t model_regs [32];

function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, logic word, xlen_t a, xlen_t b);
   logic [31:0] w;
   xlen_t       r;
   case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = xlen_t'($signed(a) < $signed(b));
      3'd3: r = xlen_t'(a < b);
      3'd4: r = a ^ b;
      3'd5: r = alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
      3'd6: r = a | b;
      default: r = a & b;
   endcase
   if (word) begin
      case (f3)
         3'd1:    w = a[31:0] << b[4:0];
         3'd5:    w = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
         default: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      endcase
      r = {{32{w[31]}}, w};
   end
   return r;
endfunction

function automatic exp_t ref_exec(insn_t insn, xlen_t pc);
   exp_t       r;
   logic [6:0] opc;
   logic [2:0] f3;
   logic [6:0] f7;
   logic       f7_ok;
   xlen_t      a;
   xlen_t      b;
   xlen_t      ii;
   xlen_t      is;
   xlen_t      ib;
   xlen_t      iu;
   xlen_t      ij;
   opc   = insn[6:0];
   f3    = insn[14:12];
   f7    = insn[31:25];
   f7_ok = (f7 == 7'd0) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
   a     = model_regs[insn[19:15]];
   b     = model_regs[insn[24:20]];
   ii    = {{52{insn[31]}}, insn[31:20]};
   is    = {{52{insn[31]}}, insn[31:25], insn[11:7]};
   ib    = {{51{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
   iu    = {{32{insn[31]}}, insn[31:12], 12'd0};
   ij    = {{43{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
   r = '{ILLEGAL, insn[11:7], '0, 1'b0, '0, f3[1:0], 1'b0, 0, 0};
   case (opc)
      OPC_OP_IMM: begin
         r.value = alu_ref(f3, f3 == 3'd5 && insn[30], 1'b0, a, ii);
         if ((f3 != 3'd1 && f3 != 3'd5) || insn[31:26] == 6'd0 ||
             (f3 == 3'd5 && insn[31:26] == 6'h10))
            r.kind = ALU;
      end
      OPC_OP_IMM_32: begin
         r.value = alu_ref(f3, f3 == 3'd5 && insn[30], 1'b1, a, ii);
         if (f3 == 3'd0 || ((f3 == 3'd1 || f3 == 3'd5) && f7_ok))
            r.kind = ALU;
      end
      OPC_OP: begin
         r.value = alu_ref(f3, f7[5], 1'b0, a, b);
         if (f7_ok)
            r.kind = ALU;
      end
      OPC_OP_32: begin
         r.value = alu_ref(f3, f7[5], 1'b1, a, b);
         if (f7_ok && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
            r.kind = ALU;
      end
      OPC_LUI: begin
         r.kind  = ALU;
         r.value = iu;
      end
      OPC_AUIPC: begin
         r.kind  = ALU;
         r.value = pc + iu;
      end
      OPC_JAL: begin
         r = '{JUMP, insn[11:7], pc + 4, 1'b1, pc + ij, f3[1:0], 1'b0, 0, 0};
      end
      OPC_JALR: begin
         if (f3 == 3'd0)
            r = '{JUMP, insn[11:7], pc + 4, 1'b1, (a + ii) & ~xlen_t'(1), f3[1:0], 1'b0, 0, 0};
      end
      OPC_BRANCH: begin
         r.target = pc + ib;
         case (f3)
            3'd0: r.taken = (a == b);
            3'd1: r.taken = (a != b);
            3'd4: r.taken = ($signed(a) < $signed(b));
            3'd5: r.taken = ($signed(a) >= $signed(b));
            3'd6: r.taken = (a < b);
            3'd7: r.taken = (a >= b);
            default: r.taken = 1'b0;
         endcase
         if (f3 != 3'd2 && f3 != 3'd3)
            r.kind = BRANCH;
      end
      OPC_LOAD: begin
         r.value = a + ii;
         if (f3 != 3'd7)
            r.kind = LOAD;
      end
      OPC_STORE: begin
         r.value = a + is;
         if (!f3[2])
            r.kind = STORE;
      end
      default: r.kind = ILLEGAL;
   endcase
   r.rd_we = (r.kind == ALU || r.kind == JUMP) && (r.rd != 5'd0);
   return r;
endfunction

//--- sim/tb_rv_exec_top.sv
`timescale 1ns/100ps

module tb_rv_exec_top import rv_exec_pkg::*; ();

   `include "tb_rv_exec_ref.svh"

   logic              i_clk;
   logic              i_rst_n;
   logic              i_insn_valid;
   insn_t             i_insn;
   xlen_t             i_pc;
   logic              o_insn_credit;
   logic              i_res_credit;
   logic              o_res_valid;
   res_kind_e         o_res_kind;
   reg_addr_t         o_res_rd;
   xlen_t             o_res_value;
   logic              o_res_taken;
   xlen_t             o_res_target;
   logic [SIZE_W-1:0] o_res_size;

   exp_t  exp_q [$];
   int    due_q [$];     // Cycles at which credits go back.
   int    cyc;
   int    n_sent;
   int    n_ret;
   int    out_cnt;
   xlen_t pc;

   rv_exec_top i_dut (.*);

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   // ---------------------------------------
   // Compare tasks
   // ---------------------------------------
   task automatic check_kind(res_kind_e got, res_kind_e exp, string what);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_reg(reg_addr_t got, reg_addr_t exp, string what);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_word(xlen_t got, xlen_t exp, string what);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic stop_run(string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   // ---------------------------------------
   // Monitor, downstream agent and timeout
   // ---------------------------------------
   always @(posedge i_clk) begin
      exp_t e;
      if (i_rst_n) begin
         if (o_insn_credit) begin
            if (n_ret >= n_sent)
               stop_run("Input credit returned with no instruction outstanding.");
            n_ret++;
         end
         out_cnt += int'(o_res_valid) - int'(i_res_credit);
         if (out_cnt > RES_CREDITS)
            stop_run("More results outstanding than output credits.");
         if (o_res_valid) begin
            if (exp_q.size() == 0)
               stop_run("Result record arrived with no expectation pending.");
            e = exp_q.pop_front();
            due_q.push_back(cyc + $urandom_range(0, 5));
            check_kind(o_res_kind, e.kind, "kind");
            check_reg(o_res_rd, e.rd, "rd");
            if (e.kind == ALU || e.kind == JUMP || e.kind == LOAD || e.kind == STORE)
               check_word(o_res_value, e.value, "value");
            if (e.kind == JUMP || e.kind == BRANCH) begin
               check_word(xlen_t'(o_res_taken), xlen_t'(e.taken), "taken");
               check_word(o_res_target, e.target, "target");
            end
            if (e.kind == LOAD || e.kind == STORE)
               check_word(xlen_t'(o_res_size), xlen_t'(e.size), "size");
            if (e.lat != 0 && cyc - e.sent != e.lat)
               stop_run($sformatf("Latency was %0d edges instead of %0d.", cyc - e.sent, e.lat));
         end
         cyc++;
         if (cyc > 20 * n_sent + 200)
            stop_run($sformatf("Run timed out with %0d expectations still pending.",
                               exp_q.size()));
      end
   end

   initial begin
      i_res_credit = 1'b0;
      forever begin
         @(negedge i_clk);
         i_res_credit = (due_q.size() > 0 && due_q[0] <= cyc);
         if (i_res_credit)
            void'(due_q.pop_front());
      end
   end

   // ---------------------------------------
   // Upstream agent and encoders
   // ---------------------------------------
   task automatic send(insn_t insn, bit lat_chk);
      exp_t e;
      while (INSN_CREDITS - n_sent + n_ret == 0) begin
         i_insn_valid = 1'b0;
         @(negedge i_clk);
      end
      e      = ref_exec(insn, pc);
      e.lat  = lat_chk ? 2 : 0;
      e.sent = cyc;
      exp_q.push_back(e);
      if (e.rd_we)
         model_regs[e.rd] = e.value;
      i_insn_valid = 1'b1;
      i_insn       = insn;
      i_pc         = pc;
      pc           = pc + 4;
      n_sent++;
      @(negedge i_clk);
      i_insn_valid = 1'b0;
   endtask

   function automatic insn_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd,
                                   logic [6:0] opc);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc};
   endfunction

   function automatic insn_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                   logic [6:0] opc);
      return {imm, 5'(rs1), f3, 5'(rd), opc};
   endfunction

   function automatic insn_t enc_s(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3,
                                   logic [6:0] opc);
      if (opc == OPC_BRANCH)
         return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opc};
      return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], opc};
   endfunction

   // ---------------------------------------
   // Stimulus
   // ---------------------------------------
   initial begin
      logic [6:0] rand_opc [6];
      void'($urandom(26));
      rand_opc = '{OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32, OPC_BRANCH, OPC_LOAD};
      foreach (model_regs[i])
         model_regs[i] = '0;
      {cyc, n_sent, n_ret, out_cnt} = '0;
      pc           = 64'h1000;
      i_rst_n      = 1'b0;
      i_insn_valid = 1'b0;
      i_insn       = '0;
      i_pc         = '0;
      repeat (8) @(negedge i_clk);
      i_rst_n = 1'b1;
      @(negedge i_clk);
      // ALU operations and W forms.
      send(enc_i(-12'sd5, 0, 3'd0, 1, OPC_OP_IMM), 1'b1);
      send(enc_i(12'd100, 0, 3'd0, 2, OPC_OP_IMM), 1'b0);
      send(enc_i(12'd0, 1, 3'd2, 3, OPC_OP_IMM), 1'b0);
      send(enc_i(12'd5, 1, 3'd3, 4, OPC_OP_IMM), 1'b0);
      for (int f = 0; f < 8; f++) begin
         send(enc_r(7'h00, 2, 1, 3'(f), 5 + f, OPC_OP), 1'b0);
         send(enc_r(7'h20, 2, 1, 3'(f), 5 + f, OPC_OP), 1'b0);
      end
      send(enc_i(12'd60, 2, 3'd1, 7, OPC_OP_IMM), 1'b0);
      send(enc_i(12'h403, 1, 3'd5, 8, OPC_OP_IMM), 1'b0);    // SRAI.
      send(enc_i(12'd4, 1, 3'd5, 9, OPC_OP_IMM), 1'b0);
      send({20'h7ffff, 5'd13, OPC_LUI}, 1'b0);
      send(enc_i(12'h7ff, 13, 3'd0, 14, OPC_OP_IMM_32), 1'b0);
      send(enc_r(7'h00, 13, 13, 3'd0, 15, OPC_OP_32), 1'b0);  // Negative sum.
      send(enc_r(7'h20, 13, 1, 3'd0, 15, OPC_OP_32), 1'b0);
      send(enc_i(12'd4, 13, 3'd1, 16, OPC_OP_IMM_32), 1'b0);
      send(enc_i(12'h404, 15, 3'd5, 17, OPC_OP_IMM_32), 1'b0);
      send(enc_r(7'h00, 2, 15, 3'd5, 18, OPC_OP_32), 1'b0);
      send(enc_r(7'h20, 2, 15, 3'd5, 18, OPC_OP_32), 1'b0);
      send(enc_r(7'h00, 2, 13, 3'd1, 19, OPC_OP_32), 1'b0);
      // Upper immediates and jumps.
      send({20'hfedcb, 5'd20, OPC_AUIPC}, 1'b0);
      send({20'h8010a, 5'd21, OPC_JAL}, 1'b0);
      send(enc_i(12'd5, 2, 3'd0, 22, OPC_JALR), 1'b0);       // Odd target.
      foreach (rand_opc[k])
         send(enc_s(13'h1f0 + 13'(k * 4), 2, 1, 3'(k < 2 ? k : k + 2), OPC_BRANCH), 1'b0);
      for (int f = 0; f < 8; f++) begin
         send(enc_i(12'(f * 3), 2, 3'(f), 23, OPC_LOAD), 1'b0);
         send(enc_s(-13'sd9, 1, 2, 3'(f), OPC_STORE), 1'b0);
      end
      send(enc_r(7'h00, 0, 23, 3'd0, 24, OPC_OP), 1'b0);
      send(enc_i(12'd7, 1, 3'd0, 0, OPC_OP_IMM), 1'b0);
      send(enc_r(7'h00, 0, 0, 3'd0, 25, OPC_OP), 1'b0);
      // FENCE, ECALL, EBREAK and random encodings.
      send(32'h0ff0000f, 1'b0);
      send(32'h00000073, 1'b0);
      send(32'h00100073, 1'b0);
      repeat (20)
         send({$urandom()} | 32'h3, 1'b0);
      // Latency from an idle pipeline.
      while (exp_q.size() != 0 || out_cnt != 0)
         @(negedge i_clk);
      send(enc_i(12'd1, 2, 3'd0, 26, OPC_OP_IMM), 1'b1);
      // Back-to-back random traffic.
      repeat (60)
         send({$urandom()} & ~32'h7f | 32'(rand_opc[$urandom_range(0, 5)]), 1'b0);
      while (exp_q.size() != 0)
         @(negedge i_clk);
      repeat (10) @(negedge i_clk);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
